/* include/wisc_consts.svh */
`ifndef WISC_CONSTS_SVH
`define WISC_CONSTS_SVH

//////////////////////////////////////////////////
// Fetch address constants
//////////////////////////////////////////////////

// First fetch address out of reset
`define WISC_RESET_PC 16'h0000

// Instructions are one 16-bit word, so sequential fetch steps by 2 bytes
`define WISC_PC_STEP 16'd2

//////////////////////////////////////////////////
// Branch predictor table geometry
//////////////////////////////////////////////////

// Index comes from PC[3:1], byte bit 0 is always zero
`define WISC_BP_INDEX_BITS 3

// One history bit and one target entry per index
`define WISC_BP_ENTRIES (1 << `WISC_BP_INDEX_BITS)

`endif

/* src/wiscPkg.sv */
`default_nettype none

package wiscPkg;

    //////////////////////////////////////////////////
    // Instruction set
    //////////////////////////////////////////////////

    // Four-bit opcode field, top nibble of every instruction
    typedef enum logic [3:0] {
        ADD    = 4'h0,  // Arithmetic, sets Z N V
        SUB    = 4'h1,
        XOR    = 4'h2,  // Logic, sets Z only
        RED    = 4'h3,  // Reduction add, no flags
        SLL    = 4'h4,  // Shifts use the immediate
        SRA    = 4'h5,
        ROR    = 4'h6,
        PADDSB = 4'h7,  // Packed saturating add, no flags
        LW     = 4'h8,  // Memory ops
        SW     = 4'h9,
        LLB    = 4'hA,  // Byte loads into rd
        LHB    = 4'hB,
        B      = 4'hC,  // Conditional branch, immediate offset
        BR     = 4'hD,  // Conditional branch, register target
        PCS    = 4'hE,  // Writes PC plus 2 to rd
        HLT    = 4'hF   // Stops fetch
    } opcodeT;

    //////////////////////////////////////////////////
    // Addresses
    //////////////////////////////////////////////////

    // Byte address into instruction memory
    typedef logic [15:0] addrT;

endpackage

`default_nettype wire

/* src/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit import wiscPkg::*; (
    input  opcodeT opcode,        // Opcode of the instruction in decode
    input  logic   actualTaken,   // Resolved branch direction
    input  logic   idPredTaken,   // Direction guessed when this instruction was fetched
    input  addrT   idPredTarget,  // Target guessed when this instruction was fetched
    input  addrT   actualTarget,  // Resolved branch target

    output logic   branch,        // B or BR in decode
    output logic   wenBtb,        // Target table write enable
    output logic   wenBht,        // History table write enable
    output logic   updatePc,      // Redirect fetch to actualTarget
    output logic   rollback,      // Redirect fetch to the fall-through path

    output opcodeT aluOp,         // ALU function select
    output logic   aluSrc,        // Immediate as second ALU operand
    output logic   regSrc,        // Read port 1 takes rd instead of rs
    output logic   zEn,           // Z flag update
    output logic   nvEn,          // N and V flag update
    output logic   memEnable,     // Data memory access
    output logic   memWrite,      // Data memory store
    output logic   regWrite,      // Register file write
    output logic   memToReg,      // Write back from memory
    output logic   hlt,           // Halt
    output logic   pcs            // Save PC into rd
);

    logic [3:0] op;               // Raw bits for the product terms
    logic       mispredicted;     // Guessed direction was wrong
    logic       targetMiscomp;    // Guessed target was wrong
    logic       branchTaken;      // Branch in decode actually goes

    assign op = opcode;

    //////////////////////////////////////////////////
    // Branch verdicts
    //////////////////////////////////////////////////

    assign branch        = op[3] & op[2] & ~op[1];          // 110x
    assign branchTaken   = branch & actualTaken;
    assign mispredicted  = idPredTaken != actualTaken;
    assign targetMiscomp = idPredTarget != actualTarget;

    // Refresh the target whenever a branch goes or the stored one is stale
    assign wenBtb   = branch & (actualTaken | targetMiscomp);
    assign wenBht   = branch & mispredicted;                // Learn only on a wrong guess
    assign updatePc = branchTaken & (mispredicted | targetMiscomp);

    // Predicted taken but fell through, so fetch resumes after the branch
    assign rollback = branch & idPredTaken & ~actualTaken;

    //////////////////////////////////////////////////
    // Execute stage lines
    //////////////////////////////////////////////////

    assign aluOp = opcode;                                  // ALU decodes the opcode itself

    // Shifts 4..6, memory ops 8..9, byte loads A..B
    assign aluSrc = (~op[3] & op[2] & ~op[1])
                  | (~op[3] & op[2] & op[1] & ~op[0])
                  | (op[3] & ~op[2]);

    assign regSrc = op[3] & ~op[2] & op[1];                 // 101x
    assign zEn    = ~op[3] & ~(op[1] & op[0]);              // Skips RED and PADDSB
    assign nvEn   = ~op[3] & ~op[2] & ~op[1];               // 000x

    //////////////////////////////////////////////////
    // Memory and write back lines
    //////////////////////////////////////////////////

    assign memEnable = op[3] & ~op[2] & ~op[1];             // 100x
    assign memWrite  = op[3] & ~op[2] & ~op[1] & op[0];
    assign memToReg  = op[3] & ~op[2] & ~op[1] & ~op[0];

    // All ALU ops, LW, LLB, LHB and PCS write a register
    assign regWrite = ~op[3]
                    | (op[3] & ~op[2] & ~op[0])              // LW, LLB
                    | (op[3] & ~op[2] & op[1])               // LLB, LHB
                    | (op[3] & op[2] & op[1] & ~op[0]);      // PCS

    assign hlt = &op;
    assign pcs = op[3] & op[2] & op[1] & ~op[0];

endmodule

`default_nettype wire

/* src/branchPredictor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wisc_consts.svh"

module branchPredictor import wiscPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,            // Blocks table writes
    input  addrT fetchPc,          // Lookup address
    input  addrT idPc,             // Address of the resolving branch
    input  logic wenBtb,
    input  logic wenBht,
    input  logic actualTaken,      // New history bit
    input  addrT actualTarget,     // New target
    output logic fetchPredTaken,
    output addrT fetchPredTarget
);

    localparam int Entries = `WISC_BP_ENTRIES;

    // Tables
    logic bht       [Entries];     // One-bit direction history
    logic btbValid  [Entries];     // Target entry has been written
    addrT btbTarget [Entries];     // Stored targets

    logic [`WISC_BP_INDEX_BITS-1:0] fetchIdx;
    logic [`WISC_BP_INDEX_BITS-1:0] updIdx;
    logic                           writeOk;

    // Word aligned PCs, so the index skips bit 0
    assign fetchIdx = fetchPc[`WISC_BP_INDEX_BITS:1];
    assign updIdx   = idPc[`WISC_BP_INDEX_BITS:1];
    assign writeOk  = ~stall;

    //////////////////////////////////////////////////
    // Lookup, same cycle as fetch
    //////////////////////////////////////////////////

    // Taken only when a target is known for this slot
    assign fetchPredTaken  = bht[fetchIdx] & btbValid[fetchIdx];
    assign fetchPredTarget = btbTarget[fetchIdx];

    //////////////////////////////////////////////////
    // Update from decode
    //////////////////////////////////////////////////

    // Direction and valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < Entries; i++) begin
                bht[i]      <= 1'b0;
                btbValid[i] <= 1'b0;
            end
        end else if (writeOk) begin
            if (wenBht)
                bht[updIdx] <= actualTaken;
            if (wenBtb)
                btbValid[updIdx] <= 1'b1;
        end
    end

    // Target payload, guarded by btbValid
    always_ff @(posedge clk) begin
        if (writeOk && wenBtb)
            btbTarget[updIdx] <= actualTarget;
    end

endmodule

`default_nettype wire

/* src/fetchPcGen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wisc_consts.svh"

module fetchPcGen import wiscPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,            // Hazard hold from outside
    input  logic hlt,              // HLT in decode
    input  logic updatePc,         // Taken branch redirect
    input  logic rollback,         // Not-taken recovery
    input  addrT actualTarget,
    input  logic fetchPredTaken,   // Predictor guess for fetchPc
    input  addrT fetchPredTarget,
    output addrT fetchPc,
    output addrT idPc,             // IF/ID copy of the fetch address
    output addrT idPredTarget,
    output logic idPredTaken,
    output logic flush             // Squash the instruction fetched this cycle
);

    addrT nextPc;
    logic advance;                 // Pipeline moves this edge

    assign advance = ~stall;
    assign flush   = updatePc | rollback;

    //////////////////////////////////////////////////
    // Next fetch address
    //////////////////////////////////////////////////

    always_comb begin
        if (stall || hlt)
            nextPc = fetchPc;                          // Hold
        else if (updatePc)
            nextPc = actualTarget;                     // Go to resolved target
        else if (rollback)
            nextPc = idPc + `WISC_PC_STEP;             // Fall through after branch
        else if (fetchPredTaken)
            nextPc = fetchPredTarget;                  // Follow the guess
        else
            nextPc = fetchPc + `WISC_PC_STEP;
    end

    always_ff @(posedge clk) begin
        if (rst)
            fetchPc <= `WISC_RESET_PC;
        else
            fetchPc <= nextPc;
    end

    //////////////////////////////////////////////////
    // IF/ID prediction latch
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            idPc         <= `WISC_RESET_PC;
            idPredTaken  <= 1'b0;
            idPredTarget <= `WISC_RESET_PC;
        end else if (advance) begin
            idPc         <= fetchPc;
            idPredTaken  <= fetchPredTaken & ~flush;   // Squashed slot carries no guess
            idPredTarget <= fetchPredTarget;
        end
    end

endmodule

`default_nettype wire

/* src/fetchDecodeTop.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchDecodeTop import wiscPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   stall,
    input  opcodeT opcode,         // Decode stage opcode
    input  logic   actualTaken,
    input  addrT   actualTarget,
    output addrT   fetchPc,        // Instruction memory address
    output logic   flush,
    output opcodeT aluOp,
    output logic   aluSrc,
    output logic   regSrc,
    output logic   zEn,
    output logic   nvEn,
    output logic   memEnable,
    output logic   memWrite,
    output logic   regWrite,
    output logic   memToReg,
    output logic   hlt,
    output logic   pcs,
    output logic   branch
);

    // Decoder to predictor and fetch
    logic wenBtb;
    logic wenBht;
    logic updatePc;
    logic rollback;

    // Predictor guess at fetch
    logic fetchPredTaken;
    addrT fetchPredTarget;

    // IF/ID copies
    addrT idPc;
    addrT idPredTarget;
    logic idPredTaken;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    controlUnit uCtrl (
        .opcode(opcode), .actualTaken(actualTaken), .idPredTaken(idPredTaken),
        .idPredTarget(idPredTarget), .actualTarget(actualTarget),
        .branch(branch), .wenBtb(wenBtb), .wenBht(wenBht),
        .updatePc(updatePc), .rollback(rollback),
        .aluOp(aluOp), .aluSrc(aluSrc), .regSrc(regSrc), .zEn(zEn), .nvEn(nvEn),
        .memEnable(memEnable), .memWrite(memWrite), .regWrite(regWrite),
        .memToReg(memToReg), .hlt(hlt), .pcs(pcs)
    );

    //////////////////////////////////////////////////
    // Prediction and fetch
    //////////////////////////////////////////////////

    branchPredictor uBp (
        .clk(clk), .rst(rst), .stall(stall), .fetchPc(fetchPc), .idPc(idPc),
        .wenBtb(wenBtb), .wenBht(wenBht), .actualTaken(actualTaken),
        .actualTarget(actualTarget), .fetchPredTaken(fetchPredTaken),
        .fetchPredTarget(fetchPredTarget)
    );

    fetchPcGen uPc (
        .clk(clk), .rst(rst), .stall(stall), .hlt(hlt), .updatePc(updatePc),
        .rollback(rollback), .actualTarget(actualTarget),
        .fetchPredTaken(fetchPredTaken), .fetchPredTarget(fetchPredTarget),
        .fetchPc(fetchPc), .idPc(idPc), .idPredTarget(idPredTarget),
        .idPredTaken(idPredTaken), .flush(flush)
    );

endmodule

`default_nettype wire

/* tests/tbFetchDecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wisc_consts.svh"

module tbFetchDecode import wiscPkg::*; ();

    localparam int SettleNs  = 10;  // Sample point after the falling edge
    localparam int WaitLimit = 16;  // Cycles allowed to reach a table slot

    // DUT inputs
    logic   clk;
    logic   rst;
    logic   stall;
    opcodeT opcode;
    logic   actualTaken;
    addrT   actualTarget;

    // DUT outputs
    addrT   fetchPc;
    logic   flush;
    opcodeT aluOp;
    logic   aluSrc;
    logic   regSrc;
    logic   zEn;
    logic   nvEn;
    logic   memEnable;
    logic   memWrite;
    logic   regWrite;
    logic   memToReg;
    logic   hlt;
    logic   pcs;
    logic   branch;

    logic [15:0]                    lfsrState;
    int                             errorCount;
    addrT                           learnedTarget;  // Target taught to the predictor
    logic [`WISC_BP_INDEX_BITS-1:0] bIdx;           // Slot of the trained branch

    fetchDecodeTop DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic compareVal(input logic [15:0] actual, input logic [15:0] expected,
                              input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0d ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic failTimeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", WaitLimit, what);
        $display("ERRORS FOUND");
        $fatal(1, "Stopped on a timeout");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawBits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val       = {val[14:0], lfsrState[15]};  // One step per bit
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // Expected lines in the order branch down to pcs
    function automatic logic [10:0] expectedLines(input opcodeT op);
        logic [3:0] code;
        code = op;
        return {op inside {B, BR},
                op inside {SLL, SRA, ROR, LW, SW, LLB, LHB},   // Immediate operand
                op inside {LLB, LHB},
                (code < 4'd8) && !(op inside {RED, PADDSB}),   // Z flag writers
                op inside {ADD, SUB},
                op inside {LW, SW},
                op == SW,
                !(op inside {SW, B, BR, HLT}),                 // Register writers
                op == LW,
                op == HLT,
                op == PCS};
    endfunction

    task automatic resetDut;
        @(negedge clk);
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    // Step until fetchPc lands in the trained slot
    task automatic waitForIndex(input string what);
        int n;
        n = 0;
        while (fetchPc[`WISC_BP_INDEX_BITS:1] != bIdx) begin
            if (n == WaitLimit)
                failTimeout(what);
            @(negedge clk);
            #SettleNs;
            n++;
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic decodeTable;
        logic [10:0] lines;
        stall        = 1'b1;        // Fetch frozen so only decode moves
        actualTaken  = 1'b0;
        actualTarget = `WISC_RESET_PC;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            opcode = opcodeT'(i[3:0]);
            #SettleNs;
            lines = {branch, aluSrc, regSrc, zEn, nvEn, memEnable, memWrite,
                     regWrite, memToReg, hlt, pcs};
            compareVal(16'(lines), 16'(expectedLines(opcode)),
                       $sformatf("control lines for opcode %0d", i));
            compareVal(16'(aluOp), 16'(opcode), "aluOp pass through");
            if (!(opcode inside {B, BR}))
                compareVal(16'(flush), 16'd0, "flush on a non-branch");
        end
    endtask

    task automatic sequentialFetch;
        addrT expPc;
        resetDut;
        stall  = 1'b0;
        opcode = ADD;
        expPc  = `WISC_RESET_PC;
        repeat (8) begin
            #SettleNs;
            compareVal(fetchPc, expPc, "sequential fetchPc");
            expPc = expPc + `WISC_PC_STEP;
            @(negedge clk);
        end
        #SettleNs;
    endtask

    task automatic branchLearning;
        addrT        branchPc;
        logic [15:0] r;
        @(negedge clk);
        branchPc = fetchPc - `WISC_PC_STEP;          // Decode holds the previous fetch
        bIdx     = branchPc[`WISC_BP_INDEX_BITS:1];
        drawBits(12, r);
        learnedTarget = {r[11:0], bIdx ^ 3'b100, 1'b0};  // Even target in another slot
        opcode        = B;
        actualTaken   = 1'b1;
        actualTarget  = learnedTarget;
        #SettleNs;
        compareVal(16'(flush), 16'd1, "flush on the first taken branch");
        @(negedge clk);
        opcode      = ADD;
        actualTaken = 1'b0;
        #SettleNs;
        compareVal(fetchPc, learnedTarget, "fetchPc after the taken redirect");
        waitForIndex("a refetch of the trained slot");
        @(negedge clk);
        opcode      = B;            // Slot's branch resolves as predicted
        actualTaken = 1'b1;
        #SettleNs;
        compareVal(fetchPc, learnedTarget, "fetchPc from the target buffer");
        compareVal(16'(flush), 16'd0, "flush on a correct prediction");
        @(negedge clk);
        opcode      = ADD;
        actualTaken = 1'b0;
    endtask

    task automatic rollbackRecovery;
        addrT        branchPc;
        logic [15:0] r;
        @(negedge clk);
        #SettleNs;
        waitForIndex("a second visit to the trained slot");
        branchPc = fetchPc;
        @(negedge clk);
        drawBits(1, r);
        opcode       = r[0] ? BR : B;
        actualTaken  = 1'b0;        // Right target but wrong direction
        actualTarget = learnedTarget;
        #SettleNs;
        compareVal(fetchPc, learnedTarget, "fetchPc following the prediction");
        compareVal(16'(flush), 16'd1, "flush on rollback");
        @(negedge clk);
        opcode = ADD;
        #SettleNs;
        compareVal(fetchPc, branchPc + `WISC_PC_STEP, "fetchPc after rollback");
    endtask

    task automatic stallHold;
        addrT        heldPc;
        addrT        slotPc;
        logic [15:0] r;
        @(negedge clk);
        #SettleNs;
        waitForIndex("the trained slot before the stall");
        @(negedge clk);             // Branch of the trained slot in decode
        drawBits(13, r);
        stall        = 1'b1;
        opcode       = r[12] ? BR : B;
        actualTaken  = 1'b1;
        actualTarget = {r[11:0], bIdx ^ 3'b100, 1'b0};  // Would retrain the slot
        heldPc       = fetchPc;
        #SettleNs;
        repeat (4) begin
            @(negedge clk);
            #SettleNs;
            compareVal(fetchPc, heldPc, "fetchPc under stall");
        end
        @(negedge clk);
        stall       = 1'b0;
        opcode      = ADD;
        actualTaken = 1'b0;
        #SettleNs;
        compareVal(fetchPc, heldPc, "fetchPc at stall release");
        waitForIndex("the trained slot after the stall");
        slotPc = fetchPc;
        @(negedge clk);
        #SettleNs;
        compareVal(fetchPc, slotPc + `WISC_PC_STEP, "refetch after the stall");
    endtask

    task automatic haltResume;
        addrT expPc;
        @(negedge clk);
        opcode = HLT;
        #SettleNs;
        expPc = fetchPc;
        repeat (5) begin
            @(negedge clk);
            #SettleNs;
            compareVal(fetchPc, expPc, "fetchPc under HLT");
        end
        @(negedge clk);
        opcode = ADD;
        repeat (4) begin
            @(negedge clk);
            #SettleNs;
            expPc = expPc + `WISC_PC_STEP;
            compareVal(fetchPc, expPc, "fetchPc resuming after HLT");
        end
    endtask

    initial begin
        errorCount   = 0;
        lfsrState    = 16'd10683;
        rst          = 1'b1;
        stall        = 1'b0;
        opcode       = ADD;
        actualTaken  = 1'b0;
        actualTarget = `WISC_RESET_PC;
        resetDut;
        decodeTable;
        sequentialFetch;
        branchLearning;
        rollbackRecovery;
        stallHold;
        haltResume;
        if (errorCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
src/wiscPkg.sv
src/controlUnit.sv
src/branchPredictor.sv
src/fetchPcGen.sv
src/fetchDecodeTop.sv
tests/tbFetchDecode.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tbFetchDecode -o simFetchDecode

status=0
./obj_dir/simFetchDecode > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -q "^NO ERRORS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
